/* readout_top.f */
+incdir+src
src/daq_pkg.sv
src/readout_sequencer.sv
src/ram_readout.sv
src/word_merger.sv
src/readout_top.sv
sim/microroc_model.sv
sim/tb_readout_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_readout_top -Mdir obj_dir -o tb_readout_top \
  -f readout_top.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_readout_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "simulation did not report success"
exit 1

/* sim/microroc_model.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module microroc_model #(
  parameter int MAX_WORDS = 20
) (
  input  logic                                  Clk,
  input  logic                                  start_readout,
  input  logic                                  enable,
  input  int                                    delay,
  input  int                                    count,
  input  logic [MAX_WORDS-1:0][`DAQ_WORD_W-1:0] words,
  output logic                                  dout,
  output logic                                  transmit_on_n
);

  // both lines idle high
  logic line_n = 1'b1;
  logic tx_n   = 1'b1;
  int   w;
  int   b;

  assign dout          = line_n;
  assign transmit_on_n = tx_n;

  //////////////////////////////
  // RAM readout slot
  //////////////////////////////

  // pulses during a transmission are ignored
  always @(posedge Clk) begin
    if (start_readout && enable) begin
      // chip latency before the first bit
      repeat (delay) @(posedge Clk);
      for (w = 0; w < count; w++) begin
        // MSB first, active low
        for (b = `DAQ_WORD_W - 1; b >= 0; b--) begin
          tx_n   <= 1'b0;
          line_n <= ~words[w][b];
          repeat (`DAQ_BIT_PERIOD) @(posedge Clk);
        end
      end
      // end of slot
      tx_n   <= 1'b1;
      line_n <= 1'b1;
    end
  end

endmodule

/* sim/tb_readout_top.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module tb_readout_top
  import daq_pkg::*;
();

  localparam int N          = `DAQ_NUM_CHIPS;
  localparam int MAX_WORDS  = 20;
  localparam int BUSY_LIMIT = N * 2 * `DAQ_CHIP_TIMEOUT + 200;

  typedef enum logic [1:0] {bp_open, bp_random, bp_stall} bp_mode_t;

  // DUT pins
  logic         Clk       = 1'b0;
  logic         reset_n   = 1'b0;
  logic         start     = 1'b0;
  logic         out_ready = 1'b1;
  logic [N-1:0] dout;
  logic [N-1:0] transmit_on_n;
  logic [N-1:0] start_readout;
  logic         busy;
  logic [N-1:0] chip_timeout;
  logic [N-1:0] dropped;
  tagged_word_t out_word;
  logic         out_valid;

  // chip model setup
  logic [MAX_WORDS-1:0][`DAQ_WORD_W-1:0] tx_words [N];
  logic [N-1:0] tx_enable = '1;
  int           tx_delay [N];
  int           tx_count [N];

  // scoreboard
  word_t        exp_words [N][MAX_WORDS];
  int           exp_cnt [N];
  int           rcv_idx [N];
  int           rcv_got [N];
  int           slot_cnt [N];
  logic [N-1:0] lossy = '0;
  logic [N-1:0] drop_allowed = '0;
  logic [N-1:0] timeout_allowed = '0;
  logic         check_order = 1'b0;
  int           last_chip = 0;
  int           errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  logic         hung = 1'b0;

  bp_mode_t     bp_mode = bp_open;
  logic [31:0]  stim_rng = 32'd32227;
  logic [31:0]  bp_rng = 32'd32227;
  logic [31:0]  burst_seed;
  int           err0;
  int           c;

  always #5 Clk = ~Clk;

  readout_top i_dut (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .start         (start),
    .dout          (dout),
    .transmit_on_n (transmit_on_n),
    .start_readout (start_readout),
    .busy          (busy),
    .chip_timeout  (chip_timeout),
    .dropped       (dropped),
    .out_word      (out_word),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  for (genvar i = 0; i < N; i++) begin : g_chip
    microroc_model #(.MAX_WORDS(MAX_WORDS)) i_model (
      .Clk           (Clk),
      .start_readout (start_readout[i]),
      .enable        (tx_enable[i]),
      .delay         (tx_delay[i]),
      .count         (tx_count[i]),
      .words         (tx_words[i]),
      .dout          (dout[i]),
      .transmit_on_n (transmit_on_n[i])
    );
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    stim_rng = xorshift32(stim_rng);
    return lo + int'(stim_rng % 32'(hi - lo + 1));
  endfunction

  //////////////////////////////
  // output side
  //////////////////////////////

  // sink readiness, at least 75% high in random mode
  always @(posedge Clk) begin
    case (bp_mode)
      bp_random: begin
        bp_rng = xorshift32(bp_rng);
        out_ready <= (bp_rng[1:0] != 2'b00);
      end
      bp_stall: out_ready <= 1'b0;
      default:  out_ready <= 1'b1;
    endcase
  end

  // every accepted transfer against the per-chip list
  always @(posedge Clk) begin : monitor
    int    ch;
    word_t got;
    if (reset_n && out_valid && out_ready) begin
      ch  = int'(out_word.chip);
      got = out_word.data;
      rcv_got[ch] = rcv_got[ch] + 1;
      // a lossy chip may skip its dropped words
      if (lossy[ch]) begin
        while (rcv_idx[ch] < exp_cnt[ch] && exp_words[ch][rcv_idx[ch]] != got) begin
          rcv_idx[ch] = rcv_idx[ch] + 1;
        end
      end
      assert (rcv_idx[ch] < exp_cnt[ch]) else begin
        errors = errors + 1;
        $display("error %0t: chip %0d delivered unexpected word %h", $time, ch, got);
      end
      if (rcv_idx[ch] < exp_cnt[ch]) begin
        assert (got == exp_words[ch][rcv_idx[ch]]) else begin
          errors = errors + 1;
          $display("error %0t: chip %0d word %0d is %h, expected %h",
                   $time, ch, rcv_idx[ch], got, exp_words[ch][rcv_idx[ch]]);
        end
        rcv_idx[ch] = rcv_idx[ch] + 1;
      end
      assert (!check_order || ch >= last_chip) else begin
        errors = errors + 1;
        $display("error %0t: chip %0d word after chip %0d", $time, ch, last_chip);
      end
      last_chip = ch;
    end
  end

  // start_readout pulses per chip
  always @(posedge Clk) begin
    if (!reset_n) begin
      slot_cnt <= '{default: 0};
    end else begin
      for (int i = 0; i < N; i++) begin
        if (start_readout[i]) begin
          slot_cnt[i] <= slot_cnt[i] + 1;
        end
      end
    end
  end

  //////////////////////////////
  // port protocol
  //////////////////////////////

  out_held: assert property (@(posedge Clk) disable iff (!reset_n)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else begin
      errors = errors + 1;
      $display("error %0t: out_word changed while stalled", $time);
    end

  no_drop: assert property (@(posedge Clk) disable iff (!reset_n)
    (dropped & ~drop_allowed) == '0)
    else begin
      errors = errors + 1;
      $display("error %0t: unexpected drop flags %b", $time, dropped);
    end

  no_timeout: assert property (@(posedge Clk) disable iff (!reset_n)
    (chip_timeout & ~timeout_allowed) == '0)
    else begin
      errors = errors + 1;
      $display("error %0t: unexpected timeout flags %b", $time, chip_timeout);
    end

  busy_rise: assert property (@(posedge Clk) disable iff (!reset_n)
    start && !busy |=> busy)
    else begin
      errors = errors + 1;
      $display("error %0t: busy did not follow start", $time);
    end

  one_slot: assert property (@(posedge Clk) disable iff (!reset_n)
    $onehot0(start_readout))
    else begin
      errors = errors + 1;
      $display("error %0t: several start_readout lines at once", $time);
    end

  // all chips silent once the sequence ends
  idle_at_end: assert property (@(posedge Clk) disable iff (!reset_n)
    $fell(busy) |-> &transmit_on_n)
    else begin
      errors = errors + 1;
      $display("error %0t: busy fell during a transmission", $time);
    end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic reset_dut();
    @(posedge Clk);
    reset_n <= 1'b0;
    start   <= 1'b0;
    bp_mode <= bp_open;
    repeat (10) @(posedge Clk);
    // clean scoreboard for the next test
    for (int i = 0; i < N; i++) begin
      exp_cnt[i]   = 0;
      rcv_idx[i]   = 0;
      rcv_got[i]   = 0;
      tx_count[i]  = 0;
      tx_delay[i]  = 1;
      tx_enable[i] = 1'b1;
    end
    lossy           = '0;
    drop_allowed    = '0;
    timeout_allowed = '0;
    check_order     = 1'b0;
    last_chip       = 0;
    reset_n <= 1'b1;
    @(posedge Clk);
  endtask

  // random words to a chip and its expected list
  task automatic load_chip(input int ch, input int n);
    int k;
    for (k = 0; k < n; k++) begin
      stim_rng = xorshift32(stim_rng);
      tx_words[ch][k]  = stim_rng[23:8];
      exp_words[ch][k] = stim_rng[23:8];
    end
    exp_cnt[ch]   = n;
    tx_count[ch]  = n;
    tx_delay[ch]  = rand_range(1, 8);
    tx_enable[ch] = 1'b1;
  endtask

  task automatic pulse_start();
    @(posedge Clk);
    start <= 1'b1;
    @(posedge Clk);
    start <= 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit, input string what);
    int n;
    if (hung) return;
    n = 0;
    while (busy !== level && n < limit) begin
      @(negedge Clk);
      n++;
    end
    if (busy !== level) begin
      hung = 1'b1;
      $display("timeout: %s within %0d cycles", what, limit);
    end
  endtask

  // output quiet for 16 cycles in a row
  task automatic drain_output(input int limit);
    int n;
    int idle;
    if (hung) return;
    n    = 0;
    idle = 0;
    while (idle < 16 && n < limit) begin
      @(negedge Clk);
      idle = out_valid ? 0 : idle + 1;
      n++;
    end
    if (idle < 16) begin
      hung = 1'b1;
      $display("timeout: output stream did not drain within %0d cycles", limit);
    end
  endtask

  task automatic run_readout(input bp_mode_t mode, input logic second_start);
    @(posedge Clk);
    bp_mode <= mode;
    pulse_start();
    wait_busy(1'b1, 16, "busy did not rise after start");
    if (second_start && !hung) begin
      repeat (40) @(negedge Clk);
      assert (busy) else begin
        errors = errors + 1;
        $display("error %0t: readout ended before the second start", $time);
      end
      pulse_start();
    end
    wait_busy(1'b0, BUSY_LIMIT, "busy did not fall after the last chip");
    @(posedge Clk);
    bp_mode <= bp_open;
    drain_output(2000);
  endtask

  // every exact chip delivered its whole list
  task automatic check_delivery();
    int i;
    for (i = 0; i < N; i++) begin
      assert (lossy[i] || rcv_got[i] == exp_cnt[i]) else begin
        errors = errors + 1;
        $display("error %0t: chip %0d delivered %0d of %0d words",
                 $time, i, rcv_got[i], exp_cnt[i]);
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (errors == err0 && !hung) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED", num, name);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    // one word each, chips in slot order
    err0 = errors;
    reset_dut();
    check_order = 1'b1;
    for (c = 0; c < N; c++) load_chip(c, 1);
    run_readout(bp_open, 1'b0);
    check_delivery();
    end_test(1, "single word per chip");

    err0 = errors;
    reset_dut();
    burst_seed = stim_rng;
    for (c = 0; c < N; c++) load_chip(c, rand_range(3, 6));
    run_readout(bp_open, 1'b0);
    check_delivery();
    end_test(2, "multi-word burst");

    // same bursts again, with a random sink
    err0 = errors;
    reset_dut();
    stim_rng = burst_seed;
    for (c = 0; c < N; c++) load_chip(c, rand_range(3, 6));
    run_readout(bp_random, 1'b0);
    check_delivery();
    end_test(3, "moderate back-pressure");

    // sink stalled for the whole readout
    err0 = errors;
    reset_dut();
    load_chip(0, 16);
    for (c = 1; c < N; c++) load_chip(c, 1);
    lossy[0]        = 1'b1;
    drop_allowed[0] = 1'b1;
    run_readout(bp_stall, 1'b0);
    check_delivery();
    assert (dropped[0] && rcv_got[0] >= `DAQ_FIFO_DEPTH) else begin
      errors = errors + 1;
      $display("error %0t: chip 0 overrun not seen, dropped %b, %0d words",
               $time, dropped, rcv_got[0]);
    end
    end_test(4, "overrun");

    err0 = errors;
    reset_dut();
    for (c = 0; c < N; c++) load_chip(c, rand_range(1, 3));
    tx_enable[2]       = 1'b0;
    exp_cnt[2]         = 0;
    timeout_allowed[2] = 1'b1;
    run_readout(bp_open, 1'b0);
    check_delivery();
    assert (chip_timeout == timeout_allowed) else begin
      errors = errors + 1;
      $display("error %0t: chip_timeout is %b, expected %b", $time, chip_timeout,
               timeout_allowed);
    end
    end_test(5, "silent chip timeout");

    err0 = errors;
    reset_dut();
    for (c = 0; c < N; c++) load_chip(c, rand_range(3, 6));
    run_readout(bp_open, 1'b1);
    check_delivery();
    for (c = 0; c < N; c++) begin
      assert (slot_cnt[c] == 1) else begin
        errors = errors + 1;
        $display("error %0t: chip %0d got %0d slots, expected 1", $time, c, slot_cnt[c]);
      end
    end
    end_test(6, "start while busy");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !hung) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src/daq_macros.svh */
`ifndef DAQ_MACROS_SVH
`define DAQ_MACROS_SVH

//////////////////////////////
// readout chain sizing
//////////////////////////////

// chips on the readout chain, one deserializer each
`define DAQ_NUM_CHIPS 4

// serial word width from the chip RAM
`define DAQ_WORD_W 16

//////////////////////////////
// serial line timing
//////////////////////////////

// system clocks per serial bit
`define DAQ_BIT_PERIOD 8
// divider count where the bit is sampled, mid period
`define DAQ_SAMPLE_PHASE 3

// merger output FIFO entries
`define DAQ_FIFO_DEPTH 8
// clocks to wait for a chip to start, and again to finish
`define DAQ_CHIP_TIMEOUT 4096

`endif

/* src/daq_pkg.sv */
`include "daq_macros.svh"

package daq_pkg;

  //////////////////////////////
  // data path types
  //////////////////////////////

  // one deserialized RAM word
  typedef logic [`DAQ_WORD_W-1:0] word_t;

  // chip index on the chain
  typedef logic [$clog2(`DAQ_NUM_CHIPS)-1:0] chip_id_t;

  // word tagged with its source chip, as it leaves the merger
  typedef struct packed {
    chip_id_t chip;
    word_t    data;
  } tagged_word_t;

  //////////////////////////////
  // control types
  //////////////////////////////

  // readout sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_wait_tx,
    st_in_tx,
    st_next
  } seq_state_t;

endpackage

/* src/ram_readout.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module ram_readout
  import daq_pkg::*;
(
  input  logic  Clk,
  input  logic  reset_n,
  input  logic  dout,
  input  logic  transmit_on_n,
  input  logic  armed,
  input  logic  word_ready,
  output word_t word,
  output logic  word_valid,
  output logic  dropped
);

  localparam int W     = `DAQ_WORD_W;
  localparam int DIV_W = $clog2(`DAQ_BIT_PERIOD);
  localparam int BIT_W = $clog2(`DAQ_WORD_W);

  logic             dout_meta;
  logic             dout_sync;
  logic             tx_meta;
  logic             tx_sync;
  logic             active;
  logic             sample;
  logic             last_bit;
  logic             word_done;
  logic             load;
  logic             overrun;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  word_t            shift_word;

  //////////////////////////////
  // input synchronizer
  //////////////////////////////

  // both pins are active low and idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      dout_meta <= 1'b1;
      dout_sync <= 1'b1;
      tx_meta   <= 1'b1;
      tx_sync   <= 1'b1;
    end else begin
      dout_meta <= dout;
      dout_sync <= dout_meta;
      tx_meta   <= transmit_on_n;
      tx_sync   <= tx_meta;
    end
  end

  // our window, armed and chip transmitting
  assign active = armed && !tx_sync;

  //////////////////////////////
  // bit period divider
  //////////////////////////////

  // held at zero outside the window, restarts each window
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      div_cnt <= '0;
    end else if (!active || div_cnt == DIV_W'(`DAQ_BIT_PERIOD - 1)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // mid-bit strobe
  assign sample   = active && (div_cnt == DIV_W'(`DAQ_SAMPLE_PHASE));
  assign last_bit = (bit_cnt == BIT_W'(W - 1));

  // bit position within the word
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      bit_cnt <= '0;
    end else if (!active) begin
      bit_cnt <= '0;
    end else if (sample) begin
      bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
    end
  end

  // MSB first, line inverted back to true polarity
  always_ff @(posedge Clk) begin
    if (sample) begin
      shift_word[(W - 1) - int'(bit_cnt)] <= ~dout_sync;
    end
  end

  // word complete, shift register settled next cycle
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      word_done <= 1'b0;
    end else begin
      word_done <= sample && last_bit;
    end
  end

  //////////////////////////////
  // hold register
  //////////////////////////////

  // free slot, or the old word leaves this cycle
  assign load    = word_done && (!word_valid || word_ready);
  // chip cannot wait, new word is lost
  assign overrun = word_done && word_valid && !word_ready;

  always_ff @(posedge Clk) begin
    if (load) begin
      word <= shift_word;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      word_valid <= 1'b0;
    end else if (load) begin
      word_valid <= 1'b1;
    end else if (word_ready) begin
      word_valid <= 1'b0;
    end
  end

  // sticky until reset
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      dropped <= 1'b0;
    end else if (overrun) begin
      dropped <= 1'b1;
    end
  end

  // a stalled word stays offered and unchanged
  assert property (@(posedge Clk) disable iff (!reset_n)
    word_valid && !word_ready |=> word_valid && $stable(word))
    else $error("hold word changed while stalled");

endmodule

/* src/readout_sequencer.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module readout_sequencer
  import daq_pkg::*;
(
  input  logic                      Clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  logic [`DAQ_NUM_CHIPS-1:0] transmit_on_n,
  output logic [`DAQ_NUM_CHIPS-1:0] start_readout,
  output logic [`DAQ_NUM_CHIPS-1:0] armed,
  output logic                      busy,
  output logic [`DAQ_NUM_CHIPS-1:0] chip_timeout
);

  localparam int N     = `DAQ_NUM_CHIPS;
  localparam int TMR_W = $clog2(`DAQ_CHIP_TIMEOUT);

  seq_state_t       state;
  chip_id_t         idx;
  logic [TMR_W-1:0] timer;
  logic [N-1:0]     tx_meta;
  logic [N-1:0]     tx_sync;
  logic [N-1:0]     idx_mask;
  logic             tx_low;
  logic             tmo_hit;
  logic             last_chip;

  //////////////////////////////
  // transmit line synchronizer
  //////////////////////////////

  // transmit lines idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      tx_meta <= '1;
      tx_sync <= '1;
    end else begin
      tx_meta <= transmit_on_n;
      tx_sync <= tx_meta;
    end
  end

  // current chip decode
  assign idx_mask  = {{(N-1){1'b0}}, 1'b1} << idx;
  assign tx_low    = !tx_sync[idx];
  assign tmo_hit   = (timer == TMR_W'(`DAQ_CHIP_TIMEOUT - 1));
  assign last_chip = (idx == chip_id_t'(N - 1));
  assign busy      = (state != st_idle);

  //////////////////////////////
  // slot FSM
  //////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= st_idle;
      idx           <= '0;
      timer         <= '0;
      start_readout <= '0;
      armed         <= '0;
      chip_timeout  <= '0;
    end else begin
      // start pulse lasts one cycle
      start_readout <= '0;
      case (state)
        st_idle: begin
          // start while busy never reaches here
          if (start) begin
            idx          <= '0;
            chip_timeout <= '0;
            state        <= st_start;
          end
        end
        st_start: begin
          // pulse the chip and arm its deserializer together
          start_readout <= idx_mask;
          armed         <= idx_mask;
          timer         <= '0;
          state         <= st_wait_tx;
        end
        st_wait_tx: begin
          if (tx_low) begin
            timer <= '0;
            state <= st_in_tx;
          end else if (tmo_hit) begin
            // chip never answered
            chip_timeout[idx] <= 1'b1;
            armed             <= '0;
            state             <= st_next;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        st_in_tx: begin
          if (!tx_low) begin
            armed <= '0;
            state <= st_next;
          end else if (tmo_hit) begin
            // stuck transmitting
            chip_timeout[idx] <= 1'b1;
            armed             <= '0;
            state             <= st_next;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        st_next: begin
          if (last_chip) begin
            state <= st_idle;
          end else begin
            idx   <= idx + 1'b1;
            state <= st_start;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // only the chip in its slot owns the chain
  assert property (@(posedge Clk) disable iff (!reset_n)
    armed == ((state == st_wait_tx || state == st_in_tx) ? idx_mask : '0))
    else $error("more than one chip armed or armed outside its slot");

endmodule

/* src/readout_top.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module readout_top
  import daq_pkg::*;
(
  input  logic                      Clk,
  input  logic                      reset_n,
  input  logic                      start,
  input  logic [`DAQ_NUM_CHIPS-1:0] dout,
  input  logic [`DAQ_NUM_CHIPS-1:0] transmit_on_n,
  output logic [`DAQ_NUM_CHIPS-1:0] start_readout,
  output logic                      busy,
  output logic [`DAQ_NUM_CHIPS-1:0] chip_timeout,
  output logic [`DAQ_NUM_CHIPS-1:0] dropped,
  output tagged_word_t              out_word,
  output logic                      out_valid,
  input  logic                      out_ready
);

  // sequencer to deserializers
  logic [`DAQ_NUM_CHIPS-1:0] armed;

  // deserializers to merger
  word_t                     chip_word [`DAQ_NUM_CHIPS-1:0];
  logic [`DAQ_NUM_CHIPS-1:0] word_valid;
  logic [`DAQ_NUM_CHIPS-1:0] word_ready;

  //////////////////////////////
  // slot control
  //////////////////////////////

  readout_sequencer i_sequencer (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .start         (start),
    .transmit_on_n (transmit_on_n),
    .start_readout (start_readout),
    .armed         (armed),
    .busy          (busy),
    .chip_timeout  (chip_timeout)
  );

  // one deserializer per chip
  for (genvar i = 0; i < `DAQ_NUM_CHIPS; i++) begin : i_chip
    ram_readout i_ram_readout (
      .Clk           (Clk),
      .reset_n       (reset_n),
      .dout          (dout[i]),
      .transmit_on_n (transmit_on_n[i]),
      .armed         (armed[i]),
      .word_ready    (word_ready[i]),
      .word          (chip_word[i]),
      .word_valid    (word_valid[i]),
      .dropped       (dropped[i])
    );
  end

  //////////////////////////////
  // tag and buffer
  //////////////////////////////

  word_merger i_merger (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .word       (chip_word),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

/* src/word_merger.sv */
`timescale 1ns/100ps
`include "daq_macros.svh"

module word_merger
  import daq_pkg::*;
(
  input  logic                      Clk,
  input  logic                      reset_n,
  input  word_t                     word [`DAQ_NUM_CHIPS-1:0],
  input  logic [`DAQ_NUM_CHIPS-1:0] word_valid,
  output logic [`DAQ_NUM_CHIPS-1:0] word_ready,
  output tagged_word_t              out_word,
  output logic                      out_valid,
  input  logic                      out_ready
);

  localparam int N     = `DAQ_NUM_CHIPS;
  localparam int DEPTH = `DAQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  chip_id_t         rr_ptr;
  chip_id_t         gnt_idx;
  logic             gnt_found;
  logic             wr_en;
  logic             rd_en;
  logic             fifo_full;
  logic             fifo_empty;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  tagged_word_t     wr_entry;
  tagged_word_t     fifo_mem [DEPTH];

  //////////////////////////////
  // round robin arbiter
  //////////////////////////////

  // search starts one past the last winner
  always_comb begin
    chip_id_t cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_ptr;
    for (int k = 0; k < N; k++) begin
      cand = chip_id_t'((int'(rr_ptr) + k) % N);
      if (!gnt_found && word_valid[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  // one transfer per cycle and only with room in the FIFO
  assign wr_en = gnt_found && !fifo_full;

  always_comb begin
    word_ready = '0;
    if (wr_en) begin
      word_ready[gnt_idx] = 1'b1;
    end
  end

  // advance priority past the winner
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      rr_ptr <= '0;
    end else if (wr_en) begin
      rr_ptr <= (gnt_idx == chip_id_t'(N - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  // tag with the source chip
  assign wr_entry.chip = gnt_idx;
  assign wr_entry.data = word[gnt_idx];

  //////////////////////////////
  // output FIFO
  //////////////////////////////

  assign fifo_full  = (fifo_cnt == CNT_W'(DEPTH));
  assign fifo_empty = (fifo_cnt == '0);
  assign rd_en      = out_valid && out_ready;

  always_ff @(posedge Clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= wr_entry;
    end
  end

  // circular pointers and fill count
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // head of FIFO is the output stream
  assign out_word  = fifo_mem[rd_ptr];
  assign out_valid = !fifo_empty;

  // write into a full FIFO or read from an empty one leaves the count range
  assert property (@(posedge Clk) disable iff (!reset_n)
    fifo_cnt <= CNT_W'(DEPTH))
    else $error("FIFO written when full or read when empty");

  // pointer distance tracks the fill count
  assert property (@(posedge Clk) disable iff (!reset_n)
    (int'(wr_ptr) - int'(rd_ptr) + DEPTH) % DEPTH == int'(fifo_cnt) % DEPTH)
    else $error("FIFO pointers disagree with fill count");

endmodule
